// File: dv/ipu_vectors.txt
// Columns: op, sew (0 = 8, 1 = 16, 2 = 32 bit), s1, s2, carry, expected result
// op: 0 add, 1 sub, 2 adc, 3 min, 4 minu, 5 max, 6 maxu, 7 and, 8 or, 9 xor
0 2 00000005 00000003 0 00000008
0 2 FFFFFFFF 00000001 0 00000000
0 1 0001FFFF 00010001 0 00020000
0 0 01020304 10FF2030 0 11012334
1 2 00000010 00000003 0 0000000D
1 2 00000000 00000001 0 FFFFFFFF
1 1 00050003 00060001 0 FFFF0002
1 0 80007F10 01010120 0 7FFF7EF0
2 2 00000001 00000002 1 00000004
2 2 00000001 00000002 E 00000003
2 1 0000FFFF 00000000 2 0001FFFF
2 0 10203040 01010101 5 11223142
7 2 F0F0F0F0 FF00FF00 0 F000F000
8 1 12340000 0000ABCD 0 1234ABCD
9 0 FFFF0000 0F0F0F0F 0 F0F00F0F
7 0 12345678 0F0F0F0F 0 02040608
8 2 A5A5A5A5 5A5A0000 0 FFFFA5A5
9 1 12345678 12345678 0 00000000
3 0 80017FFE 7F02FF01 0 8001FFFE
4 0 80017FFE 7F02FF01 0 7F017F01
5 0 80017FFE 7F02FF01 0 7F027F01
6 0 80017FFE 7F02FF01 0 8002FFFE
3 1 8000FFFF 00010001 0 8000FFFF
4 1 8000FFFF 00010001 0 00010001
5 1 8000FFFF 00010001 0 00010001
6 1 8000FFFF 00010001 0 8000FFFF
3 1 FFFE7FFF FFFF8000 0 FFFE8000
5 0 F0E0D0C0 E0F0C0D0 0 F0F0D0D0
4 2 80000000 7FFFFFFF 0 7FFFFFFF
3 2 80000000 7FFFFFFF 0 80000000
0 0 FFFFFFFF 01010101 0 00000000
1 1 00000000 00010001 0 FFFFFFFF

// File: files.f
verilog/ipu_data_pkg.sv
verilog/ipu_op_pkg.sv
verilog/ipu_issue_stage.sv
verilog/ipu_distributor.sv
verilog/ipu_simd_lane.sv
verilog/ipu_collector.sv
verilog/ipu.sv
dv/ipu_assertions.sv
dv/ipu_tb.sv

// File: Makefile
TOP := ipu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir

// File: dv/ipu_tb.sv
//////////////////////////////////////////////////
// IPU testbench
// Vector driven stimulus, random back-pressure
// and in-order result checking
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ipu_tb import ipu_data_pkg::*; import ipu_op_pkg::*; ();

    localparam int NUM_VECTORS = 32;
    localparam int FIELDS      = 6;
    localparam int TIMEOUT     = 200;

    logic       clk_i;
    logic       rst_n_i;
    op_e        operation_i;
    logic       operation_valid_i;
    logic       operation_ready_o;
    elen_t      op_s1_i;
    elen_t      op_s2_i;
    elenb_t     carry_i;
    vew_e       sew_i;
    logic [3:0] tag_i;
    elen_t      result_o;
    elenb_t     result_valid_o;
    logic       result_ready_i;
    logic [3:0] tag_o;
    logic       busy_o;

    // op, sew, s1, s2, carry, expected per vector
    logic [31:0] vectors [NUM_VECTORS*FIELDS];

    int unsigned error_count;
    int unsigned check_count;
    int unsigned timeout_count;
    int          sent;
    int          received;
    int          accepted;

    ipu #(.tag_t(logic [3:0])) dut0 (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .operation_i      (operation_i),
        .operation_valid_i(operation_valid_i),
        .operation_ready_o(operation_ready_o),
        .op_s1_i          (op_s1_i),
        .op_s2_i          (op_s2_i),
        .carry_i          (carry_i),
        .sew_i            (sew_i),
        .tag_i            (tag_i),
        .result_o         (result_o),
        .result_valid_o   (result_valid_o),
        .result_ready_i   (result_ready_i),
        .tag_o            (tag_o),
        .busy_o           (busy_o)
    );

    bind ipu ipu_assertions #(.TagWidth(4)) u_ipu_assertions (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .operation_ready_i(operation_ready_o),
        .result_i         (result_o),
        .result_valid_i   (result_valid_o),
        .result_ready_i   (result_ready_i),
        .tag_i            (tag_o),
        .busy_i           (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
    endtask

    task automatic load_vector(input int idx);
        int base;
        base = idx * FIELDS;
        operation_i <= op_e'(vectors[base][3:0]);
        sew_i       <= vew_e'(vectors[base+1][1:0]);
        op_s1_i     <= vectors[base+2];
        op_s2_i     <= vectors[base+3];
        carry_i     <= vectors[base+4][3:0];
        tag_i       <= 4'(idx);
    endtask

    task automatic check_result(input int idx);
        check_value($sformatf("result of vector %0d", idx), result_o, vectors[idx*FIELDS+5]);
        check_value($sformatf("byte valids of vector %0d", idx), 32'(result_valid_o), 32'hF);
        check_value($sformatf("tag of vector %0d", idx), 32'(tag_o), 32'(idx % 16));
    endtask

    task automatic drive_all();
        int cycles;
        sent   = 0;
        cycles = 0;
        load_vector(0);
        operation_valid_i <= 1'b1;
        while (sent < NUM_VECTORS && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
            if (operation_valid_i && operation_ready_o) begin
                sent++;
                cycles = 0;
                if (sent < NUM_VECTORS) begin
                    load_vector(sent);
                end else begin
                    operation_valid_i <= 1'b0;
                end
            end
        end
        if (sent < NUM_VECTORS) begin
            report_timeout("operation_ready_o");
            operation_valid_i <= 1'b0;
        end
    endtask

    task automatic collect_all();
        int cycles;
        received = 0;
        cycles   = 0;
        while (received < NUM_VECTORS && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
            if (|result_valid_o && result_ready_i) begin
                check_result(received);
                received++;
                cycles = 0;
            end
            // Ready about three cycles in four
            result_ready_i <= ($urandom % 4) != 0;
        end
        if (received < NUM_VECTORS) begin
            report_timeout("result_valid_o");
        end
        result_ready_i <= 1'b1;
    endtask

    task automatic stall_test();
        int cycles;
        accepted = 0;
        received = 0;
        cycles   = 0;
        result_ready_i <= 1'b0;
        load_vector(0);
        operation_valid_i <= 1'b1;
        do begin
            @(posedge clk_i);
            cycles++;
            if (operation_valid_i && operation_ready_o) begin
                accepted++;
                load_vector(accepted);
            end
        end while (operation_ready_o && cycles < TIMEOUT);
        if (operation_ready_o) begin
            report_timeout("operation_ready_o to fall");
        end
        check_value("items accepted before ready fell", 32'(accepted), 32'd2);

        // Third item stays offered
        repeat (4) begin
            @(posedge clk_i);
            check_value("operation_ready_o while blocked", 32'(operation_ready_o), 32'd0);
            check_value("busy_o while blocked", 32'(busy_o), 32'd1);
        end

        result_ready_i <= 1'b1;
        cycles = 0;
        while (received < 3 && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
            check_value("busy_o while draining", 32'(busy_o), 32'd1);
            if (operation_valid_i && operation_ready_o) begin
                accepted++;
                operation_valid_i <= 1'b0;
            end
            if (|result_valid_o && result_ready_i) begin
                check_result(received);
                received++;
                cycles = 0;
            end
        end
        if (received < 3) begin
            report_timeout("results after the stall");
        end

        cycles = 0;
        while (busy_o && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (busy_o) begin
            report_timeout("busy_o to fall");
        end
        check_value("items accepted in stall test", 32'(accepted), 32'd3);
    endtask

    initial begin
        void'($urandom(93276));
        error_count       = 0;
        check_count       = 0;
        timeout_count     = 0;
        rst_n_i           = 1'b0;
        operation_i       = VADD;
        operation_valid_i = 1'b0;
        op_s1_i           = '0;
        op_s2_i           = '0;
        carry_i           = '0;
        sew_i             = EW_32;
        tag_i             = '0;
        result_ready_i    = 1'b0;
        $readmemh("dv/ipu_vectors.txt", vectors);

        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Idle state after reset
        @(posedge clk_i);
        check_value("result_valid_o after reset", 32'(result_valid_o), 32'd0);
        check_value("busy_o after reset", 32'(busy_o), 32'd0);
        check_value("operation_ready_o after reset", 32'(operation_ready_o), 32'd1);

        fork
            drive_all();
            collect_all();
        join
        if (timeout_count == 0) begin
            stall_test();
        end

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 check_count, error_count, timeout_count, dut0.u_ipu_assertions.fail_count);
        if (error_count == 0 && timeout_count == 0 && dut0.u_ipu_assertions.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : ipu_tb

// File: dv/ipu_assertions.sv
//////////////////////////////////////////////////
// IPU handshake checks
// Bound to the top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ipu_assertions import ipu_data_pkg::*; #(
    parameter int unsigned TagWidth = 4
) (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                operation_ready_i,
    input elen_t               result_i,
    input elenb_t              result_valid_i,
    input logic                result_ready_i,
    input logic [TagWidth-1:0] tag_i,
    input logic                busy_i
);

    int unsigned fail_count = 0;

    // Outputs frozen while the consumer stalls
    property held_while_blocked;
        @(posedge clk_i) disable iff (!rst_n_i)
        (|result_valid_i && !result_ready_i) |=>
            ($stable(result_i) && $stable(result_valid_i) && $stable(tag_i));
    endproperty

    property idle_has_no_result;
        @(posedge clk_i) disable iff (!rst_n_i)
        !busy_i |-> (result_valid_i == '0);
    endproperty

    // Both stages full and the result blocked
    property ready_low_only_when_full;
        @(posedge clk_i) disable iff (!rst_n_i)
        !operation_ready_i |-> (busy_i && (|result_valid_i) && !result_ready_i);
    endproperty

    property whole_word_valid;
        @(posedge clk_i) disable iff (!rst_n_i)
        (|result_valid_i) |-> (&result_valid_i);
    endproperty

    a_held: assert property (held_while_blocked)
        else begin
            fail_count++;
            $error("result outputs changed while result_ready_i was low");
        end

    a_idle: assert property (idle_has_no_result)
        else begin
            fail_count++;
            $error("result valid while the unit is not busy");
        end

    a_ready: assert property (ready_low_only_when_full)
        else begin
            fail_count++;
            $error("operation_ready_o low without both stages full");
        end

    a_valid: assert property (whole_word_valid)
        else begin
            fail_count++;
            $error("result valid bits are not all set");
        end

endmodule : ipu_assertions

// File: verilog/ipu.sv
//////////////////////////////////////////////////
// Integer processing unit
// Issue register, operand distribution over four
// SIMD lanes and result collection
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ipu import ipu_data_pkg::*; import ipu_op_pkg::*; #(
    parameter type tag_t = logic [3:0]
) (
    input  logic   clk_i,
    input  logic   rst_n_i,
    // Issue side
    input  op_e    operation_i,
    input  logic   operation_valid_i,
    output logic   operation_ready_o,
    input  elen_t  op_s1_i,
    input  elen_t  op_s2_i,
    input  elenb_t carry_i,
    input  vew_e   sew_i,
    input  tag_t   tag_i,
    // Result side
    output elen_t  result_o,
    output elenb_t result_valid_o,
    input  logic   result_ready_i,
    output tag_t   tag_o,
    output logic   busy_o
);

    op_e         operation;
    elen_t       op_s1;
    elen_t       op_s2;
    elenb_t      carry;
    vew_e        sew;
    logic        issue_valid;
    logic        accept;
    logic        lane_advance;
    logic        is_signed;

    logic [7:0]  lane8a_s1, lane8a_s2, lane8a_res;
    logic [7:0]  lane8b_s1, lane8b_s2, lane8b_res;
    logic [15:0] lane16_s1, lane16_s2, lane16_res;
    elen_t       lane32_s1, lane32_s2, lane32_res;
    logic        lane8a_carry, lane8a_en, lane8a_valid;
    logic        lane8b_carry, lane8b_en, lane8b_valid;
    logic        lane16_carry, lane16_en, lane16_valid;
    logic        lane32_carry, lane32_en, lane32_valid;

    ipu_issue_stage i_issue (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .operation_i      (operation_i),
        .operation_valid_i(operation_valid_i),
        .operation_ready_o(operation_ready_o),
        .op_s1_i          (op_s1_i),
        .op_s2_i          (op_s2_i),
        .carry_i          (carry_i),
        .sew_i            (sew_i),
        .result_ready_i   (result_ready_i),
        .operation_o      (operation),
        .op_s1_o          (op_s1),
        .op_s2_o          (op_s2),
        .carry_o          (carry),
        .sew_o            (sew),
        .issue_valid_o    (issue_valid),
        .accept_o         (accept),
        .lane_advance_o   (lane_advance),
        .busy_o           (busy_o)
    );

    ipu_distributor i_distributor (
        .operation_i   (operation),
        .issue_valid_i (issue_valid),
        .op_s1_i       (op_s1),
        .op_s2_i       (op_s2),
        .carry_i       (carry),
        .sew_i         (sew),
        .lane8a_s1_o   (lane8a_s1),
        .lane8a_s2_o   (lane8a_s2),
        .lane8a_carry_o(lane8a_carry),
        .lane8a_en_o   (lane8a_en),
        .lane8b_s1_o   (lane8b_s1),
        .lane8b_s2_o   (lane8b_s2),
        .lane8b_carry_o(lane8b_carry),
        .lane8b_en_o   (lane8b_en),
        .lane16_s1_o   (lane16_s1),
        .lane16_s2_o   (lane16_s2),
        .lane16_carry_o(lane16_carry),
        .lane16_en_o   (lane16_en),
        .lane32_s1_o   (lane32_s1),
        .lane32_s2_o   (lane32_s2),
        .lane32_carry_o(lane32_carry),
        .lane32_en_o   (lane32_en),
        .is_signed_o   (is_signed)
    );

    //////////////////////////////////////////////////
    // SIMD lanes
    //////////////////////////////////////////////////

    ipu_simd_lane #(.Width(8)) i_lane8a (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .operation_i(operation),
        .is_signed_i(is_signed), .enable_i(lane8a_en), .advance_i(lane_advance),
        .op_s1_i(lane8a_s1), .op_s2_i(lane8a_s2), .carry_i(lane8a_carry),
        .result_o(lane8a_res), .result_valid_o(lane8a_valid)
    );

    ipu_simd_lane #(.Width(8)) i_lane8b (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .operation_i(operation),
        .is_signed_i(is_signed), .enable_i(lane8b_en), .advance_i(lane_advance),
        .op_s1_i(lane8b_s1), .op_s2_i(lane8b_s2), .carry_i(lane8b_carry),
        .result_o(lane8b_res), .result_valid_o(lane8b_valid)
    );

    ipu_simd_lane #(.Width(16)) i_lane16 (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .operation_i(operation),
        .is_signed_i(is_signed), .enable_i(lane16_en), .advance_i(lane_advance),
        .op_s1_i(lane16_s1), .op_s2_i(lane16_s2), .carry_i(lane16_carry),
        .result_o(lane16_res), .result_valid_o(lane16_valid)
    );

    ipu_simd_lane #(.Width(32)) i_lane32 (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .operation_i(operation),
        .is_signed_i(is_signed), .enable_i(lane32_en), .advance_i(lane_advance),
        .op_s1_i(lane32_s1), .op_s2_i(lane32_s2), .carry_i(lane32_carry),
        .result_o(lane32_res), .result_valid_o(lane32_valid)
    );

    ipu_collector #(.tag_t(tag_t)) i_collector (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .accept_i       (accept),
        .advance_i      (lane_advance),
        .sew_i          (sew),
        .tag_i          (tag_i),
        .lane8a_result_i(lane8a_res),
        .lane8a_valid_i (lane8a_valid),
        .lane8b_result_i(lane8b_res),
        .lane8b_valid_i (lane8b_valid),
        .lane16_result_i(lane16_res),
        .lane16_valid_i (lane16_valid),
        .lane32_result_i(lane32_res),
        .lane32_valid_i (lane32_valid),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .tag_o          (tag_o)
    );

endmodule : ipu

// File: verilog/ipu_collector.sv
//////////////////////////////////////////////////
// IPU result collector
// Packs lane results into the element word and
// forwards the tag of the item in the lane stage
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ipu_collector import ipu_data_pkg::*; #(
    parameter type tag_t = logic [3:0]
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        accept_i,
    input  logic        advance_i,
    input  vew_e        sew_i,
    input  tag_t        tag_i,
    input  logic [7:0]  lane8a_result_i,
    input  logic        lane8a_valid_i,
    input  logic [7:0]  lane8b_result_i,
    input  logic        lane8b_valid_i,
    input  logic [15:0] lane16_result_i,
    input  logic        lane16_valid_i,
    input  elen_t       lane32_result_i,
    input  logic        lane32_valid_i,
    output elen_t       result_o,
    output elenb_t      result_valid_o,
    output tag_t        tag_o
);

    vew_e sew_q;
    tag_t tag_issue_q;

    // Tag follows its item through issue and lane stage
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            tag_issue_q <= tag_i;
        end
        if (advance_i) begin
            tag_o <= tag_issue_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sew_q <= EW_32;
        end else if (advance_i) begin
            sew_q <= sew_i;
        end
    end

    always_comb begin
        unique case (sew_q)
            EW_8: begin
                result_o       = {lane32_result_i[7:0], lane16_result_i[7:0],
                                  lane8b_result_i, lane8a_result_i};
                result_valid_o = {lane32_valid_i, lane16_valid_i, lane8b_valid_i, lane8a_valid_i};
            end
            EW_16: begin
                result_o       = {lane32_result_i[15:0], lane16_result_i};
                result_valid_o = {{2{lane32_valid_i}}, {2{lane16_valid_i}}};
            end
            default: begin
                result_o       = lane32_result_i;
                result_valid_o = {ELENB{lane32_valid_i}};
            end
        endcase
    end

endmodule : ipu_collector

// File: verilog/ipu_simd_lane.sv
//////////////////////////////////////////////////
// IPU SIMD lane
// Computes one element at Width bits and holds
// the result until the next advance
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ipu_simd_lane import ipu_op_pkg::*; #(
    parameter int unsigned Width = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  op_e              operation_i,
    input  logic             is_signed_i,
    input  logic             enable_i,
    input  logic             advance_i,
    input  logic [Width-1:0] op_s1_i,
    input  logic [Width-1:0] op_s2_i,
    input  logic             carry_i,
    output logic [Width-1:0] result_o,
    output logic             result_valid_o
);

    logic [Width-1:0] result_d;
    logic             s1_less;

    assign s1_less = is_signed_i ? ($signed(op_s1_i) < $signed(op_s2_i)) : (op_s1_i < op_s2_i);

    //////////////////////////////////////////////////
    // Element ALU
    //////////////////////////////////////////////////

    always_comb begin
        unique case (operation_i)
            VADD:  result_d = op_s1_i + op_s2_i;
            // s1 minus s2
            VSUB:  result_d = op_s1_i - op_s2_i;
            VADC:  result_d = op_s1_i + op_s2_i + Width'(carry_i);
            VMIN,
            VMINU: result_d = s1_less ? op_s1_i : op_s2_i;
            VMAX,
            VMAXU: result_d = s1_less ? op_s2_i : op_s1_i;
            VAND:  result_d = op_s1_i & op_s2_i;
            VOR:   result_d = op_s1_i | op_s2_i;
            VXOR:  result_d = op_s1_i ^ op_s2_i;
            default: result_d = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
        end else if (advance_i) begin
            result_valid_o <= enable_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            result_o <= result_d;
        end
    end

endmodule : ipu_simd_lane

// File: verilog/ipu_distributor.sv
//////////////////////////////////////////////////
// IPU operand distributor
// Splits the element word over the SIMD lanes by
// element width, with sign or zero extension
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ipu_distributor import ipu_data_pkg::*; import ipu_op_pkg::*; (
    input  op_e         operation_i,
    input  logic        issue_valid_i,
    input  elen_t       op_s1_i,
    input  elen_t       op_s2_i,
    input  elenb_t      carry_i,
    input  vew_e        sew_i,
    // 8 bit lane a
    output logic [7:0]  lane8a_s1_o,
    output logic [7:0]  lane8a_s2_o,
    output logic        lane8a_carry_o,
    output logic        lane8a_en_o,
    // 8 bit lane b
    output logic [7:0]  lane8b_s1_o,
    output logic [7:0]  lane8b_s2_o,
    output logic        lane8b_carry_o,
    output logic        lane8b_en_o,
    // 16 bit lane
    output logic [15:0] lane16_s1_o,
    output logic [15:0] lane16_s2_o,
    output logic        lane16_carry_o,
    output logic        lane16_en_o,
    // 32 bit lane
    output elen_t       lane32_s1_o,
    output elen_t       lane32_s2_o,
    output logic        lane32_carry_o,
    output logic        lane32_en_o,
    output logic        is_signed_o
);

    assign is_signed_o = is_signed_op(operation_i);

    always_comb begin
        // Unused lanes see zeros
        lane8a_s1_o    = '0;
        lane8a_s2_o    = '0;
        lane8a_carry_o = 1'b0;
        lane8a_en_o    = 1'b0;
        lane8b_s1_o    = '0;
        lane8b_s2_o    = '0;
        lane8b_carry_o = 1'b0;
        lane8b_en_o    = 1'b0;
        lane16_s1_o    = '0;
        lane16_s2_o    = '0;
        lane16_carry_o = 1'b0;
        lane16_en_o    = 1'b0;
        lane32_en_o    = issue_valid_i;

        unique case (sew_i)
            EW_8: begin
                lane8a_s1_o    = op_s1_i[7:0];
                lane8a_s2_o    = op_s2_i[7:0];
                lane8b_s1_o    = op_s1_i[15:8];
                lane8b_s2_o    = op_s2_i[15:8];
                lane16_s1_o    = is_signed_o ? 16'($signed(op_s1_i[23:16])) : 16'(op_s1_i[23:16]);
                lane16_s2_o    = is_signed_o ? 16'($signed(op_s2_i[23:16])) : 16'(op_s2_i[23:16]);
                lane32_s1_o    = is_signed_o ? 32'($signed(op_s1_i[31:24])) : 32'(op_s1_i[31:24]);
                lane32_s2_o    = is_signed_o ? 32'($signed(op_s2_i[31:24])) : 32'(op_s2_i[31:24]);
                lane8a_carry_o = carry_i[0];
                lane8b_carry_o = carry_i[1];
                lane16_carry_o = carry_i[2];
                lane32_carry_o = carry_i[3];
                lane8a_en_o    = issue_valid_i;
                lane8b_en_o    = issue_valid_i;
                lane16_en_o    = issue_valid_i;
            end
            EW_16: begin
                lane16_s1_o    = op_s1_i[15:0];
                lane16_s2_o    = op_s2_i[15:0];
                lane32_s1_o    = is_signed_o ? 32'($signed(op_s1_i[31:16])) : 32'(op_s1_i[31:16]);
                lane32_s2_o    = is_signed_o ? 32'($signed(op_s2_i[31:16])) : 32'(op_s2_i[31:16]);
                lane16_carry_o = carry_i[0];
                lane32_carry_o = carry_i[1];
                lane16_en_o    = issue_valid_i;
            end
            default: begin
                // Full word in the 32 bit lane
                lane32_s1_o    = op_s1_i;
                lane32_s2_o    = op_s2_i;
                lane32_carry_o = carry_i[0];
            end
        endcase
    end

endmodule : ipu_distributor

// File: verilog/ipu_issue_stage.sv
//////////////////////////////////////////////////
// IPU issue stage
// Holds one accepted operation and decides when
// it moves into the lane stage
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ipu_issue_stage import ipu_data_pkg::*; import ipu_op_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    // Issue side
    input  op_e    operation_i,
    input  logic   operation_valid_i,
    output logic   operation_ready_o,
    input  elen_t  op_s1_i,
    input  elen_t  op_s2_i,
    input  elenb_t carry_i,
    input  vew_e   sew_i,
    // Result side
    input  logic   result_ready_i,
    // Registered item
    output op_e    operation_o,
    output elen_t  op_s1_o,
    output elen_t  op_s2_o,
    output elenb_t carry_o,
    output vew_e   sew_o,
    output logic   issue_valid_o,
    // Flow control
    output logic   accept_o,
    output logic   lane_advance_o,
    output logic   busy_o
);

    logic lane_full_q;
    logic lane_free;

    //////////////////////////////////////////////////
    // Flow control
    //////////////////////////////////////////////////

    // Lane stage can take a new item this cycle
    assign lane_free = !lane_full_q || result_ready_i;

    // A bubble is loaded when the last result leaves, which clears the lane valids
    assign lane_advance_o    = lane_free && (issue_valid_o || lane_full_q);
    assign operation_ready_o = !issue_valid_o || lane_advance_o;
    assign accept_o          = operation_valid_i && operation_ready_o;
    assign busy_o            = issue_valid_o || lane_full_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_valid_o <= 1'b0;
            lane_full_q   <= 1'b0;
        end else begin
            if (accept_o) begin
                issue_valid_o <= 1'b1;
            end else if (lane_advance_o) begin
                issue_valid_o <= 1'b0;
            end

            // Lane stage occupancy follows what moves in
            if (lane_advance_o) begin
                lane_full_q <= issue_valid_o;
            end
        end
    end

    //////////////////////////////////////////////////
    // Operand register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            operation_o <= operation_i;
            op_s1_o     <= op_s1_i;
            op_s2_o     <= op_s2_i;
            carry_o     <= carry_i;
            sew_o       <= sew_i;
        end
    end

endmodule : ipu_issue_stage

// File: verilog/ipu_op_pkg.sv
//////////////////////////////////////////////////
// IPU operation definitions
// Operation encoding and signedness lookup
//////////////////////////////////////////////////

package ipu_op_pkg;

    typedef enum logic [3:0] {
        VADD  = 4'd0,
        VSUB  = 4'd1,
        VADC  = 4'd2,
        VMIN  = 4'd3,
        VMINU = 4'd4,
        VMAX  = 4'd5,
        VMAXU = 4'd6,
        VAND  = 4'd7,
        VOR   = 4'd8,
        VXOR  = 4'd9
    } op_e;

    // Signed compare and sign extension into wider lanes
    function automatic logic is_signed_op(op_e op);
        return op inside {VMIN, VMAX};
    endfunction

endpackage : ipu_op_pkg

// File: verilog/ipu_data_pkg.sv
//////////////////////////////////////////////////
// IPU data definitions
// Element word, per-byte vectors and the
// element width encoding
//////////////////////////////////////////////////

package ipu_data_pkg;

    // Element word
    localparam int unsigned ELEN  = 32;
    localparam int unsigned ELENB = ELEN / 8;

    typedef logic [ELEN-1:0]  elen_t;

    // One bit per byte, carries and result valids
    typedef logic [ELENB-1:0] elenb_t;

    //////////////////////////////////////////////////
    // Element width
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        EW_8  = 2'b00,
        EW_16 = 2'b01,
        EW_32 = 2'b10
    } vew_e;

endpackage : ipu_data_pkg
